// File: src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address word width
`define CPU_WORD 16

// Register slots with slot 0 read back as the flag word
`define CPU_NREG 8

// ------------------------------
// Opcodes in bits 0..5 of the instruction word
// ------------------------------
`define OP_LW  6'o20
`define OP_TW  6'o21
`define OP_RW  6'o23
`define OP_AW  6'o24
`define OP_SW  6'o26
`define OP_AWT 6'o40
`define OP_NR  6'o30
`define OP_OR  6'o31
`define OP_ER  6'o32
`define OP_UJ  6'o50
`define OP_JZ  6'o51
`define OP_HLT 6'o76

`endif

// File: src/cpu_pkg.sv
package cpu_pkg;

	// ------------------------------
	// Instruction word views
	// ------------------------------

	// Two-operand form with the argument from the next word or R[c]
	typedef struct packed {
		logic [0:5] op;
		logic d;
		logic [0:2] a;
		logic [0:2] b;
		logic [0:2] c;
	} reg_form_t;

	// Short argument form with a sign-magnitude immediate
	typedef struct packed {
		logic [0:5] op;
		logic ts;
		logic [0:2] a;
		logic [0:5] t;
	} short_form_t;

	typedef union packed {
		reg_form_t reg_form;
		short_form_t short_form;
	} instr_u;

	// Sequencer phases
	typedef enum logic [2:0] {FETCH, ARG, EXEC, MEM, WB, HALT} seq_state_e;

	typedef enum logic [2:0] {PASS, ADD, SUB, AND, OR, XOR} alu_op_e;

	// Z lands in bit 0 of the flag word
	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
	} flags_s;

endpackage

// File: src/px.sv
module px import cpu_pkg::*; (
	input logic __clk,
	input logic rst,
	input logic needs_arg,
	input logic is_mem_read,
	input logic is_mem_write,
	input logic is_halt,
	input logic mem_ready,
	output logic mem_valid,
	output logic mem_write,
	output logic fetch,
	output logic arg_fetch,
	output logic exec,
	output logic mem_op,
	output logic wb,
	output logic bus_done,
	output logic hlt
);

	seq_state_e state;
	seq_state_e state_next;

	assign bus_done = mem_valid & mem_ready;

	// Bus phases wait here for the handshake
	always_comb begin
		state_next = state;
		case (state)
			FETCH: begin
				if (bus_done) begin
					if (is_halt) begin
						state_next = HALT;
					end else if (needs_arg) begin
						state_next = ARG;
					end else begin
						state_next = EXEC;
					end
				end
			end
			ARG: begin
				if (bus_done) begin
					state_next = EXEC;
				end
			end
			EXEC: state_next = (is_mem_read | is_mem_write) ? MEM : WB;
			MEM: begin
				if (bus_done) begin
					state_next = WB;
				end
			end
			WB: state_next = FETCH;
			default: state_next = HALT;
		endcase
	end

	// Request goes up on entry to a bus phase, drops after the last one
	always_ff @(posedge __clk) begin
		if (rst) begin
			state <= FETCH;
			mem_valid <= 1'b0;
		end else begin
			state <= state_next;
			mem_valid <= (state_next == FETCH) || (state_next == ARG) || (state_next == MEM);
		end
	end

	assign fetch = (state == FETCH);
	assign arg_fetch = (state == ARG);
	assign exec = (state == EXEC);
	assign mem_op = (state == MEM);
	assign wb = (state == WB);
	assign hlt = (state == HALT);

	assign mem_write = mem_op & is_mem_write;

endmodule

// File: src/pd.sv
`include "cpu_settings.svh"

module pd import cpu_pkg::*; (
	input logic __clk,
	input logic rst,
	input logic fetch,
	input logic bus_done,
	input logic [0:`CPU_WORD-1] mem_rdata,
	input logic z,
	output alu_op_e alu_op,
	output logic [0:$clog2(`CPU_NREG)-1] reg_a,
	output logic [0:$clog2(`CPU_NREG)-1] reg_c,
	output logic needs_arg,
	output logic is_mem_read,
	output logic is_mem_write,
	output logic is_jump,
	output logic is_halt,
	output logic take_jump,
	output logic reg_we,
	output logic short_imm,
	output instr_u ir
);

	instr_u src;
	logic [0:5] op;

	always_ff @(posedge __clk) begin
		if (rst) begin
			ir <= '0;
		end else if (fetch && bus_done) begin
			ir <= mem_rdata;
		end
	end

	// During fetch the sequencer needs the word still on the bus
	assign src = fetch ? instr_u'(mem_rdata) : ir;
	assign op = src.reg_form.op;

	always_comb begin
		alu_op = PASS;
		reg_we = 1'b0;
		short_imm = 1'b0;
		is_halt = 1'b0;
		case (op)
			`OP_LW, `OP_TW: reg_we = 1'b1;
			`OP_AW: begin
				alu_op = ADD;
				reg_we = 1'b1;
			end
			`OP_SW: begin
				alu_op = SUB;
				reg_we = 1'b1;
			end
			`OP_AWT: begin
				alu_op = ADD;
				reg_we = 1'b1;
				short_imm = 1'b1;
			end
			`OP_NR: begin
				alu_op = AND;
				reg_we = 1'b1;
			end
			`OP_OR: begin
				alu_op = OR;
				reg_we = 1'b1;
			end
			`OP_ER: begin
				alu_op = XOR;
				reg_we = 1'b1;
			end
			`OP_RW, `OP_UJ, `OP_JZ: begin
			end
			// HLT and anything undefined stop the machine
			default: is_halt = 1'b1;
		endcase
	end

	assign reg_a = src.reg_form.a;
	assign reg_c = src.reg_form.c;
	assign needs_arg = !is_halt && !short_imm && (src.reg_form.c == '0);
	assign is_mem_read = (op == `OP_TW);
	assign is_mem_write = (op == `OP_RW);
	assign is_jump = (op == `OP_UJ) || (op == `OP_JZ);
	assign take_jump = is_jump && ((op == `OP_UJ) || z);

endmodule

// File: src/pr.sv
`include "cpu_settings.svh"

module pr import cpu_pkg::*; (
	input logic __clk,
	input logic rst,
	input logic [0:$clog2(`CPU_NREG)-1] reg_a,
	input logic [0:$clog2(`CPU_NREG)-1] reg_c,
	input logic reg_we,
	input logic wb,
	input logic [0:`CPU_WORD-1] wdata,
	input flags_s flags,
	output logic [0:`CPU_WORD-1] ra_data,
	output logic [0:`CPU_WORD-1] rc_data
);

	// R1..R7 only, no storage behind slot 0
	logic [0:`CPU_WORD-1] r [1:`CPU_NREG-1];
	logic [0:`CPU_WORD-1] flag_word;

	assign flag_word = {flags, {(`CPU_WORD - $bits(flags_s)){1'b0}}};

	// ------------------------------
	// Write port
	// ------------------------------
	always_ff @(posedge __clk) begin
		if (rst) begin
			for (int i = 1; i < `CPU_NREG; i++) begin
				r[i] <= '0;
			end
		end else if (wb && reg_we && (reg_a != '0)) begin
			r[reg_a] <= wdata;
		end
	end

	// ------------------------------
	// Read ports
	// ------------------------------
	assign ra_data = (reg_a == '0) ? flag_word : r[reg_a];
	assign rc_data = (reg_c == '0) ? flag_word : r[reg_c];

endmodule

// File: src/pa.sv
`include "cpu_settings.svh"

module pa import cpu_pkg::*; (
	input logic __clk,
	input logic rst,
	input logic fetch,
	input logic arg_fetch,
	input logic exec,
	input logic mem_op,
	input logic wb,
	input logic bus_done,
	input instr_u ir,
	input alu_op_e alu_op,
	input logic short_imm,
	input logic needs_arg,
	input logic take_jump,
	input logic is_mem_write,
	input logic [0:`CPU_WORD-1] ra_data,
	input logic [0:`CPU_WORD-1] rc_data,
	input logic [0:`CPU_WORD-1] mem_rdata,
	output logic [0:`CPU_WORD-1] mem_addr,
	output logic [0:`CPU_WORD-1] mem_wdata,
	output logic [0:`CPU_WORD-1] result,
	output flags_s flags,
	output logic z,
	output logic [0:`CPU_WORD-1] ic
);

	localparam int W = `CPU_WORD;

	logic [0:W-1] ar;
	logic [0:W-1] imm;
	logic [0:W-1] opb;
	logic [0:W-1] opb_eff;
	logic [0:W-1] alu_out;
	logic [0:W] sum;
	logic sub;
	logic arith;
	flags_s flags_next;

	// ------------------------------
	// ALU
	// ------------------------------

	// ts is the sign, t the magnitude
	assign imm = ir.short_form.ts ? -{{(W-6){1'b0}}, ir.short_form.t}
		: {{(W-6){1'b0}}, ir.short_form.t};
	assign opb = short_imm ? imm : ar;

	// Subtract as a + ~b + 1 with the carry out in sum[0]
	assign sub = (alu_op == SUB);
	assign arith = (alu_op == ADD) || sub;
	assign opb_eff = sub ? ~opb : opb;
	assign sum = {1'b0, ra_data} + {1'b0, opb_eff} + {{W{1'b0}}, sub};

	always_comb begin
		case (alu_op)
			ADD, SUB: alu_out = sum[1:W];
			AND: alu_out = ra_data & opb;
			OR: alu_out = ra_data | opb;
			XOR: alu_out = ra_data ^ opb;
			default: alu_out = opb;
		endcase
		flags_next.z = (alu_out == '0);
		flags_next.m = alu_out[0];
		flags_next.v = arith && (ra_data[0] == opb_eff[0]) && (sum[1] != ra_data[0]);
		flags_next.c = arith && sum[0];
	end

	// ------------------------------
	// IC and flags
	// ------------------------------
	always_ff @(posedge __clk) begin
		if (rst) begin
			ic <= '0;
			flags <= '0;
		end else begin
			if ((fetch || arg_fetch) && bus_done) begin
				ic <= ic + W'(1);
			end else if (wb && take_jump) begin
				ic <= ar;
			end
			if (exec && (alu_op != PASS)) begin
				flags <= flags_next;
			end
		end
	end

	// Argument is R[c] unless it follows in memory
	always_ff @(posedge __clk) begin
		if (fetch && bus_done && !needs_arg) begin
			ar <= rc_data;
		end else if (arg_fetch && bus_done) begin
			ar <= mem_rdata;
		end
		if (exec) begin
			result <= alu_out;
		end else if (mem_op && bus_done && !is_mem_write) begin
			result <= mem_rdata;
		end
	end

	assign mem_addr = mem_op ? ar : ic;
	assign mem_wdata = ra_data;
	assign z = flags.z;

endmodule

// File: src/cpu.sv
`include "cpu_settings.svh"

module cpu import cpu_pkg::*; (
	input logic __clk,
	input logic rst,
	output logic mem_valid,
	input logic mem_ready,
	output logic mem_write,
	output logic [0:`CPU_WORD-1] mem_addr,
	output logic [0:`CPU_WORD-1] mem_wdata,
	input logic [0:`CPU_WORD-1] mem_rdata,
	output logic hlt,
	output logic [0:`CPU_WORD-1] ic
);

	// ------------------------------
	// Sequencer phases
	// ------------------------------
	logic fetch, arg_fetch, exec, mem_op, wb, bus_done;

	// ------------------------------
	// Decoder outputs
	// ------------------------------
	logic needs_arg, is_mem_read, is_mem_write, is_halt;
	logic take_jump, reg_we, short_imm;
	alu_op_e alu_op;
	logic [0:$clog2(`CPU_NREG)-1] reg_a, reg_c;
	instr_u ir;

	// ------------------------------
	// Data path
	// ------------------------------
	logic [0:`CPU_WORD-1] ra_data, rc_data, result;
	flags_s flags;
	logic z;

	px px_i (.*);

	// Jump class is folded into take_jump inside the decoder
	pd pd_i (.*, .is_jump());

	pr pr_i (.*, .wdata(result));

	pa pa_i (.*);

endmodule

// File: verification/cpu_checker.sv
`include "cpu_settings.svh"

module cpu_checker (
	input logic __clk,
	input logic rst,
	input logic mem_valid,
	input logic mem_ready,
	input logic mem_write,
	input logic [0:`CPU_WORD-1] mem_addr,
	input logic [0:`CPU_WORD-1] mem_wdata,
	input logic hlt
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	// ------------------------------
	// Bus handshake
	// ------------------------------
	reset_idle: assert property (@(posedge __clk) rst |=> !mem_valid)
	else begin
		failures++;
		$error("mem_valid high in the cycle after a reset edge");
	end

	// Request, direction and address held until mem_ready
	hold_request: assert property (@(posedge __clk) disable iff (rst)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_write) && $stable(mem_addr))
	else begin
		failures++;
		$error("Bus request changed while waiting for mem_ready");
	end

	hold_wdata: assert property (@(posedge __clk) disable iff (rst)
		mem_valid && !mem_ready && mem_write |=> $stable(mem_wdata))
	else begin
		failures++;
		$error("Write data changed while waiting for mem_ready");
	end

	// Halted machine stays off the bus
	halt_idle: assert property (@(posedge __clk) disable iff (rst) hlt |-> !mem_valid)
	else begin
		failures++;
		$error("Bus request while halted");
	end

endmodule

// File: verification/cpu_tb.sv
`include "cpu_settings.svh"

module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int W = `CPU_WORD;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic mem_ready = 1'b0;
	logic [0:W-1] mem_rdata = '0;
	logic mem_valid;
	logic mem_write;
	logic [0:W-1] mem_addr;
	logic [0:W-1] mem_wdata;
	logic hlt;
	logic [0:W-1] ic;

	logic [0:W-1] mem [0:(1 << W) - 1];
	logic [0:W-1] exp_addr [$];
	logic [0:W-1] exp_data [$];
	logic [0:W-1] halt_ic;
	int n_words = 0;
	int seed = 32'hbe94dc93;
	logic [1:0] wait_cnt;

	cpu cpu_i (
		.__clk(clk),
		.rst(rst),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.hlt(hlt),
		.ic(ic)
	);

	bind cpu cpu_checker checker_i (
		.__clk(__clk),
		.rst(rst),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.hlt(hlt)
	);

	always #2 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [0:W-1] got,
		input logic [0:W-1] exp);
		if (got !== exp) begin
			fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
		end
	endtask

	// Writes must match the W lines in order
	task automatic take_write(input logic [0:W-1] addr, input logic [0:W-1] data);
		if (exp_addr.size() == 0) begin
			fail_run($sformatf("Unexpected bus write of %h to %h", data, addr));
		end else begin
			check_word("mem_addr", addr, exp_addr.pop_front());
			check_word("mem_wdata", data, exp_data.pop_front());
			mem[addr] = data;
		end
	endtask

	task automatic load_vectors();
		int fd;
		int ch;
		logic [7:0] kind;
		logic [0:W-1] addr;
		logic [0:W-1] word;
		for (int i = 0; i < (1 << W); i++) begin
			mem[i] = W'(i) ^ 16'h5a5a;
		end
		fd = $fopen("verification/cpu_vectors.txt", "r");
		if (fd == 0) begin
			fail_run("Cannot open verification/cpu_vectors.txt");
		end
		while ($fscanf(fd, " %c", kind) == 1) begin
			case (kind)
				"M": begin
					void'($fscanf(fd, " %h", addr));
					for (int i = 0; i < 4; i++) begin
						void'($fscanf(fd, " %h", word));
						mem[addr + W'(i)] = word;
						n_words++;
					end
				end
				"W": begin
					void'($fscanf(fd, " %h %h", addr, word));
					exp_addr.push_back(addr);
					exp_data.push_back(word);
				end
				"H": void'($fscanf(fd, " %h", halt_ic));
				"#": begin
					ch = $fgetc(fd);
					while (ch != 10 && ch != -1) begin
						ch = $fgetc(fd);
					end
				end
				default: fail_run($sformatf("Unknown line kind %s in the vector file", kind));
			endcase
		end
		$fclose(fd);
		if (n_words == 0) begin
			fail_run("The vector file holds no memory image");
		end
	endtask

	// ------------------------------
	// Memory with 0 to 3 wait states
	// ------------------------------
	always @(posedge clk) begin
		if (rst) begin
			mem_ready <= 1'b0;
			wait_cnt <= 2'($random(seed));
		end else if (mem_valid && mem_ready) begin
			if (mem_write) begin
				take_write(mem_addr, mem_wdata);
			end
			mem_ready <= 1'b0;
			wait_cnt <= 2'($random(seed));
		end else if (mem_valid) begin
			if (wait_cnt == 2'd0) begin
				mem_ready <= 1'b1;
				if (!mem_write) begin
					mem_rdata <= mem[mem_addr];
				end
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

	// Four bus phases of five cycles per memory word
	initial begin
		wait (n_words != 0);
		#(n_words * 4 * 5 * 4);
		fail_run("Watchdog expired, the CPU never halted");
	end

	initial begin
		load_vectors();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		while (!hlt) begin
			@(posedge clk);
		end
		check_word("ic", ic, halt_ic);
		repeat (20) begin
			@(posedge clk);
			check_bit("mem_valid", mem_valid, 1'b0);
		end
		check_bit("hlt", hlt, 1'b1);
		if (exp_addr.size() != 0) begin
			fail_run($sformatf("%0d expected bus writes never happened", exp_addr.size()));
		end else if (cpu_i.checker_i.failures != 0) begin
			fail_run("Bus handshake assertions failed");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// File: verification/cpu_vectors.txt
# M: start address, then four memory words; W: expected write address and data, in order
# H: expected ic once the CPU has halted
M 0000 4040 1234 4080 0FFF  # LW R1,#1234  LW R2,#0FFF
M 0004 5040 0100 4C40 0200  # AW R1,#0100  RW R1,0200
M 0008 5042 4C40 0201 5880  # AW R1,R2  RW R1,0201  SW R2,...
M 000C 1000 4C80 0202 5881  # ...#1000  RW R2,0202  SW R2,R1
M 0010 4C80 0203 80C5 82CC  # RW R2,0203  AWT R3,+5  AWT R3,-12
M 0014 4CC0 0204 4100 F0F0  # RW R3,0204  LW R4,#F0F0
M 0018 6100 3C3C 6500 0C03  # NR R4,#3C3C  OR R4,#0C03
M 001C 6901 4D00 0205 4140  # ER R4,R1  RW R4,0205  LW R5,...
M 0020 8000 5140 8000 4C00  # ...#8000  AW R5,#8000 sets Z V C  RW R0,...
M 0024 0206 A400 0029 4C40  # ...0206  JZ 0029 taken  RW R1,...
M 0028 02FF 4D40 0207 4580  # ...02FF skipped  RW R5,0207  TW R6,...
M 002C 0203 4D80 0208 8181  # ...0203  RW R6,0208  AWT R6,+1
M 0030 A400 0034 4D80 0209  # JZ 0034 not taken  RW R6,0209
M 0034 A000 0038 4D80 02FE  # UJ 0038  RW R6,02FE skipped
M 0038 F800 F800 F800 F800  # HLT
W 0200 1334
W 0201 2333
W 0202 FFFF
W 0203 DCCC
W 0204 FFF9
W 0205 1F00
W 0206 B000
W 0207 0000
W 0208 DCCC
W 0209 DCCD
H 0039

// File: all.f
+incdir+src
src/cpu_pkg.sv
src/px.sv
src/pd.sv
src/pr.sv
src/pa.sv
src/cpu.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/100ps --top-module cpu_tb -f all.f -o cpu_sim

run: compile
	@out="$$(./obj_dir/cpu_sim)"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
